// ==== verilog/period_pkg.sv ====
/* Period meter shared definitions
   Channel count, unit scaling, datapath widths, FSM states and report records */
package period_pkg;

    // Sizing of the meter
    localparam int NUM_CHANNELS   = 4;     // Measured inputs
    localparam int TICKS_PER_UNIT = 50;    // 1 us at 50 MHz
    localparam int PERIOD_MAX     = 1023;  // Largest reportable period

    // One bit per channel, used for start, si, ready and edge vectors
    typedef logic [NUM_CHANNELS-1:0] chan_mask_t;

    // Channel number
    typedef logic [1:0] chan_idx_t;

    // Measured period in whole units
    typedef logic [9:0] period_t;

    // Cycle count inside one unit, 0 to TICKS_PER_UNIT-1
    typedef logic [5:0] tick_cnt_t;

    // Per-channel measurement FSM
    typedef enum logic [1:0]
    {
        IDLE  = 2'b00,  // Waiting for start
        ARM   = 2'b01,  // Waiting for first rising edge
        COUNT = 2'b10,  // Counting until second rising edge
        DONE  = 2'b11   // One-cycle done pulse
    } meter_state_t;

    // Counter to collector, 11 bits
    typedef struct packed
    {
        logic    overflow;  // Period saturated at PERIOD_MAX
        period_t period;
    } chan_report_t;

    // Top-level result, 13 bits
    typedef struct packed
    {
        chan_idx_t channel;   // Source channel
        logic      overflow;
        period_t   period;
    } meas_result_t;

endpackage

// ==== verilog/edge_frontend.sv ====
/* Input front end for the period meter
   Two-flop synchronizers and registered rising-edge pulses for all channels */
`timescale 1ns/100ps

module edge_frontend
(
    input  logic                  clk,
    input  logic                  reset,
    input  period_pkg::chan_mask_t si,        // Asynchronous square waves
    output period_pkg::chan_mask_t edge_tick  // One-cycle rising-edge pulses
);

    import period_pkg::*;

    chan_mask_t sync1_reg;  // First synchronizer stage, may go metastable
    chan_mask_t sync2_reg;  // Second stage, safe to use
    chan_mask_t prev_reg;   // Previous synchronized value
    chan_mask_t edge_reg;   // Registered edge pulse
    chan_mask_t rise;       // Low-to-high seen this cycle

    // Rising edge on any channel
    assign rise = sync2_reg & ~prev_reg;

    // Whole vector handled at once; every channel sees the same fixed delay
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            sync1_reg <= '0;
            sync2_reg <= '0;
            prev_reg  <= '0;
            edge_reg  <= '0;
        end
        else
        begin
            sync1_reg <= si;         // Edge 0 samples the input
            sync2_reg <= sync1_reg;  // Edge 1
            prev_reg  <= sync2_reg;  // Edge 2, history for detection
            edge_reg  <= rise;       // Edge 2, pulse seen by counters at edge 3
        end
    end

    // Clean single-cycle ticks to the counters
    assign edge_tick = edge_reg;

endmodule

// ==== verilog/period_counter.sv ====
/* Single-channel period counter FSMD
   Waits for two rising edges and counts whole time units between them, saturating */
`timescale 1ns/100ps

module period_counter
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,      // Level-sampled strobe
    input  logic                    edge_tick,  // Synchronized rising edge
    output logic                    ready,      // High in IDLE only
    output logic                    done_tick,  // One cycle, report valid with it
    output period_pkg::chan_report_t report
);

    import period_pkg::*;

    meter_state_t state_reg, state_next;
    tick_cnt_t    tick_reg, tick_next;        // Cycles inside current unit
    period_t      period_reg, period_next;    // Whole units so far
    chan_report_t report_reg, report_next;    // Last finished measurement

    logic unit_end;   // Current cycle completes one unit
    logic at_max;     // Period already at the saturation point

    assign unit_end = (tick_reg == tick_cnt_t'(TICKS_PER_UNIT - 1));
    assign at_max   = (period_reg == period_t'(PERIOD_MAX));

    // Control state
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            state_reg <= IDLE;
        else
            state_reg <= state_next;
    end

    // Datapath registers
    always_ff @(posedge clk)
    begin
        tick_reg   <= tick_next;
        period_reg <= period_next;
        report_reg <= report_next;
    end

    // Next-state and datapath logic
    always_comb
    begin
        state_next  = state_reg;
        tick_next   = tick_reg;
        period_next = period_reg;
        report_next = report_reg;
        ready       = 1'b0;
        done_tick   = 1'b0;

        case (state_reg)
            IDLE:
            begin
                ready = 1'b1;
                if (start)  // Starts elsewhere are ignored
                    state_next = ARM;
            end
            ARM:  // Real wait for the first edge
            begin
                if (edge_tick)
                begin
                    state_next  = COUNT;
                    tick_next   = tick_cnt_t'(1);  // Edge cycle itself counts
                    period_next = '0;
                end
            end
            COUNT:
            begin
                if (edge_tick)  // Second edge ends the measurement
                begin
                    state_next         = DONE;
                    report_next.overflow = 1'b0;
                    report_next.period = period_reg;
                end
                else if (unit_end)
                begin
                    if (at_max)  // Next unit would pass PERIOD_MAX
                    begin
                        state_next           = DONE;
                        report_next.overflow = 1'b1;
                        report_next.period   = period_t'(PERIOD_MAX);
                    end
                    else
                    begin
                        tick_next   = '0;
                        period_next = period_reg + period_t'(1);
                    end
                end
                else
                    tick_next = tick_reg + tick_cnt_t'(1);
            end
            DONE:
            begin
                done_tick  = 1'b1;  // Report register already holds the result
                state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    assign report = report_reg;

endmodule

// ==== verilog/result_collector.sv ====
/* Result collector for the period meter
   One pending report per channel; sends the lowest-index one each cycle */
`timescale 1ns/100ps

module result_collector
(
    input  logic                     clk,
    input  logic                     reset,
    input  period_pkg::chan_mask_t   done_tick,  // One bit per counter
    input  period_pkg::chan_report_t report [period_pkg::NUM_CHANNELS],
    output logic                     result_valid,  // One pulse per result
    output period_pkg::meas_result_t result
);

    import period_pkg::*;

    chan_mask_t   pend_reg, pend_next;      // Report waiting to be sent
    chan_report_t store_reg [NUM_CHANNELS]; // Stored reports
    chan_mask_t   req;                      // Pending or arriving now
    chan_mask_t   grant;                    // Channel sent this cycle
    chan_idx_t    sel_idx;
    logic         any_req;
    chan_report_t sel_report;               // Payload of the granted channel
    meas_result_t result_next;

    // A report arriving now may go out next cycle when nothing else waits
    assign req     = pend_reg | done_tick;
    assign any_req = |req;

    // Lowest index wins
    always_comb
    begin
        sel_idx = '0;
        for (int i = NUM_CHANNELS - 1; i >= 0; i--)
        begin
            if (req[i])
                sel_idx = chan_idx_t'(i);
        end
    end

    assign grant = any_req ? chan_mask_t'(1) << sel_idx : '0;

    // Older stored report goes first; otherwise take the one arriving now
    assign sel_report = pend_reg[sel_idx] ? store_reg[sel_idx] : report[sel_idx];

    always_comb
    begin
        result_next.channel  = sel_idx;
        result_next.overflow = sel_report.overflow;
        result_next.period   = sel_report.period;
    end

    // Flag update per channel
    always_comb
    begin
        for (int i = 0; i < NUM_CHANNELS; i++)
        begin
            if (done_tick[i])
                pend_next[i] = ~(grant[i] & ~pend_reg[i]);  // Sent at once unless older one goes
            else
                pend_next[i] = pend_reg[i] & ~grant[i];
        end
    end

    // Control state
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            pend_reg     <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            pend_reg     <= pend_next;
            result_valid <= any_req;
        end
    end

    // Payload
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < NUM_CHANNELS; i++)
        begin
            if (done_tick[i])  // Newest report overwrites an unsent one
                store_reg[i] <= report[i];
        end
        if (any_req)
            result <= result_next;
    end

endmodule

// ==== verilog/period_meter_top.sv ====
/* Four-channel period meter
   Shared input front end, one counter per channel and a result collector */
`timescale 1ns/100ps

module period_meter_top
(
    input  logic                     clk,
    input  logic                     reset,
    input  period_pkg::chan_mask_t   start,        // Per-channel start strobes
    input  period_pkg::chan_mask_t   si,           // Measured square waves
    output period_pkg::chan_mask_t   ready,        // Channel idle
    output logic                     result_valid,
    output period_pkg::meas_result_t result
);

    import period_pkg::*;

    chan_mask_t   edge_tick;                // Front end to counters
    chan_mask_t   done_tick;                // Counters to collector
    chan_report_t report [NUM_CHANNELS];    // Per-channel results

    // Synchronizers and edge pulses for all inputs
    edge_frontend u_frontend
    (
        .clk       (clk),
        .reset     (reset),
        .si        (si),
        .edge_tick (edge_tick)
    );

    // One counter per channel
    for (genvar i = 0; i < NUM_CHANNELS; i++)
    begin : g_chan
        period_counter u_counter
        (
            .clk       (clk),
            .reset     (reset),
            .start     (start[i]),
            .edge_tick (edge_tick[i]),
            .ready     (ready[i]),
            .done_tick (done_tick[i]),
            .report    (report[i])
        );
    end

    // Serializes finished reports onto the single output
    result_collector u_collector
    (
        .clk          (clk),
        .reset        (reset),
        .done_tick    (done_tick),
        .report       (report),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// ==== test/period_meter_chk.sv ====
/* Assertions on the period meter top level
   Saturation, known result_valid and the start handshake */
`timescale 1ns/100ps

module period_meter_chk
(
    input logic                     clk,
    input logic                     reset,
    input period_pkg::chan_mask_t   start,
    input period_pkg::chan_mask_t   ready,
    input logic                     result_valid,
    input period_pkg::meas_result_t result
);

    import period_pkg::*;

    // Overflow only with a saturated period
    a_ovf_sat: assert property (@(posedge clk) disable iff (reset)
        result_valid && result.overflow |-> result.period == period_t'(PERIOD_MAX))
        else $error("overflow reported with period %0d", result.period);

    a_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(result_valid))
        else $error("result_valid is unknown");

    // Accepted start leaves IDLE
    for (genvar i = 0; i < NUM_CHANNELS; i++)
    begin : g_start
        a_start_drops_ready: assert property (@(posedge clk) disable iff (reset)
            start[i] && ready[i] |=> !ready[i])
            else $error("channel %0d still ready after start", i);
    end

endmodule

bind period_meter_top period_meter_chk u_chk
(
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .ready        (ready),
    .result_valid (result_valid),
    .result       (result)
);

// ==== test/period_meter_tb.sv ====
/* Testbench for the four-channel period meter
   Table-driven square-wave stimulus, result checks against whole-unit periods */
`timescale 1ns/100ps

module period_meter_tb;

    import period_pkg::*;

    localparam int NUM_ROWS = 8;
    localparam int ALL_READY = (1 << NUM_CHANNELS) - 1;

    // One stimulus row, channel fields ordered ch3 down to ch0
    typedef struct packed
    {
        chan_mask_t                    mask;        // Channels started
        logic [NUM_CHANNELS-1:0][15:0] per;         // Input period in cycles
        logic [NUM_CHANNELS-1:0][9:0]  exp_period;  // floor(P / TICKS_PER_UNIT), saturated
        logic [NUM_CHANNELS-1:0]       exp_ovf;
        logic                          sync;        // Phase 0 everywhere, fixed edge times
        logic                          restart;     // Second start while busy
    } row_t;

    logic         clk;
    logic         reset;
    chan_mask_t   start;
    chan_mask_t   si;
    chan_mask_t   ready;
    logic         result_valid;
    meas_result_t result;

    row_t        rows [NUM_ROWS];
    int unsigned wave_per [NUM_CHANNELS];    // Generator period, 0 holds si low
    int unsigned wave_start [NUM_CHANNELS];  // Phase loaded on reprogramming
    int unsigned wave_gen;                   // Bumped to reload all generators
    int unsigned limit_cycles = 0;

    period_meter_top DUT
    (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .si           (si),
        .ready        (ready),
        .result_valid (result_valid),
        .result       (result)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz sim clock
    end

    // Square wave per channel, rising edge every wave_per cycles
    for (genvar g = 0; g < NUM_CHANNELS; g++)
    begin : g_wave
        logic        level = 1'b0;
        int unsigned phase = 0;
        int unsigned seen_gen = 0;

        always @(posedge clk)
        begin
            #1;
            if (seen_gen != wave_gen)  // New row programmed
            begin
                phase    = wave_start[g];
                seen_gen = wave_gen;
            end
            if (wave_per[g] == 0)
                level = 1'b0;
            else
            begin
                level = (phase < wave_per[g] / 2);  // High half first
                if (phase + 1 >= wave_per[g])
                    phase = 0;
                else
                    phase = phase + 1;
            end
        end

        assign si[g] = level;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;  // Drive and sample clear of the edge
    endtask

    task automatic check_value(input string name, input int unsigned actual,
                               input int unsigned expected);
        if (actual != expected)
        begin
            $display("FAIL at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // Per row 3x the longest period plus slack
    function automatic int unsigned watchdog_cycles();
        int unsigned total;
        int unsigned longest;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            longest = 0;
            for (int c = 0; c < NUM_CHANNELS; c++)
                if (32'(rows[r].per[c]) > longest)
                    longest = 32'(rows[r].per[c]);
            total = total + 3 * longest + 2000;
        end
        return total;
    endfunction

    task automatic apply_row(input int r);
        row_t        row;
        chan_mask_t  seen;        // Channels reported so far
        int unsigned ch;
        int unsigned first_open;  // Lowest started channel not yet reported
        int unsigned busy_cycles;
        int unsigned longest;     // Longest started period
        int unsigned late_limit;  // Last result due by this cycle
        row     = rows[r];
        longest = 0;
        @(negedge clk);  // All generators pick up the row at the same edge
        for (int c = 0; c < NUM_CHANNELS; c++)
        begin
            wave_per[c]   = 32'(row.per[c]);
            wave_start[c] = 0;
            if (!row.sync && wave_per[c] != 0)
                wave_start[c] = $urandom % wave_per[c];  // Random starting phase
            if (row.mask[c] && wave_per[c] > longest)
                longest = wave_per[c];
        end
        // First edge within one period, second one period later, plus collector queue
        late_limit = 2 * longest + NUM_CHANNELS + 4;
        wave_gen = wave_gen + 1;
        repeat (8) next_cycle();  // A reload edge clears the front end first
        check_value("ready", 32'(ready), ALL_READY);
        start = row.mask;
        next_cycle();
        start = '0;
        check_value("ready of started channels", 32'(ready & row.mask), 0);
        seen        = '0;
        busy_cycles = 0;
        while (seen != row.mask)
        begin
            // Phase 0 puts the first edge just before this, so the channel is counting
            if (row.restart && busy_cycles == longest)
            begin
                check_value("ready before second start", 32'(ready & row.mask), 0);
                start = row.mask;  // Channel busy, must be ignored
            end
            next_cycle();
            start = '0;
            busy_cycles++;
            if (busy_cycles > late_limit)
            begin
                $display("Row %0d: a started channel gave no result within %0d cycles",
                         r, late_limit);
                $display("Done: errors found");
                $fatal(1, "result missing");
            end
            if (result_valid)
            begin
                ch = 32'(result.channel);
                check_value("result.channel started and unreported",
                            32'(row.mask[ch] & !seen[ch]), 1);
                if (row.sync)
                begin
                    first_open = 0;
                    for (int c = NUM_CHANNELS - 1; c >= 0; c--)
                        if (row.mask[c] && !seen[c])
                            first_open = c;
                    check_value("result.channel", ch, first_open);  // Rising order
                end
                check_value("result.period", 32'(result.period), 32'(row.exp_period[ch]));
                check_value("result.overflow", 32'(result.overflow), 32'(row.exp_ovf[ch]));
                seen[ch] = 1'b1;
            end
        end
        repeat (50)  // No repeated or stray results
        begin
            next_cycle();
            check_value("result_valid", 32'(result_valid), 0);
        end
        check_value("ready", 32'(ready), ALL_READY);
    endtask

    initial
    begin
        void'($urandom(53852));
        reset    = 1'b1;
        start    = '0;
        wave_gen = 0;
        for (int c = 0; c < NUM_CHANNELS; c++)
        begin
            wave_per[c]   = 0;
            wave_start[c] = 0;
        end
        // Single channels, then overflow, then all four, then a busy restart
        rows[0] = '{4'b0001, {16'd0, 16'd0, 16'd0, 16'd150},
                    {10'd0, 10'd0, 10'd0, 10'd3}, 4'b0000, 1'b0, 1'b0};
        rows[1] = '{4'b0010, {16'd0, 16'd0, 16'd149, 16'd0},
                    {10'd0, 10'd0, 10'd2, 10'd0}, 4'b0000, 1'b0, 1'b0};
        rows[2] = '{4'b0100, {16'd0, 16'd50, 16'd0, 16'd0},
                    {10'd0, 10'd1, 10'd0, 10'd0}, 4'b0000, 1'b0, 1'b0};
        rows[3] = '{4'b1000, {16'd1000, 16'd0, 16'd0, 16'd0},
                    {10'd20, 10'd0, 10'd0, 10'd0}, 4'b0000, 1'b0, 1'b0};
        rows[4] = '{4'b0001, {16'd0, 16'd0, 16'd0, 16'd60000},
                    {10'd0, 10'd0, 10'd0, 10'd1023}, 4'b0001, 1'b0, 1'b0};
        rows[5] = '{4'b1111, {16'd75, 16'd1234, 16'd520, 16'd300},
                    {10'd1, 10'd24, 10'd10, 10'd6}, 4'b0000, 1'b0, 1'b0};
        rows[6] = '{4'b1111, {16'd200, 16'd200, 16'd200, 16'd200},
                    {10'd4, 10'd4, 10'd4, 10'd4}, 4'b0000, 1'b1, 1'b0};
        rows[7] = '{4'b0100, {16'd0, 16'd400, 16'd0, 16'd0},
                    {10'd0, 10'd8, 10'd0, 10'd0}, 4'b0000, 1'b1, 1'b1};
        limit_cycles = watchdog_cycles();
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("ready", 32'(ready), ALL_READY);
        repeat (20)  // Idle, no start given
        begin
            next_cycle();
            check_value("result_valid", 32'(result_valid), 0);
        end
        for (int r = 0; r < NUM_ROWS; r++)
            apply_row(r);
        $display("Done: no errors");
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the test did not finish within %0d clock cycles", limit_cycles);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== files.f ====
verilog/period_pkg.sv
verilog/edge_frontend.sv
verilog/period_counter.sv
verilog/result_collector.sv
verilog/period_meter_top.sv
test/period_meter_chk.sv
test/period_meter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the period meter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f files.f --top-module period_meter_tb -o period_meter_sim

out=$(./obj_dir/period_meter_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Done: no errors"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
